// ==== rtl/core_types_pkg.sv ====
package core_types_pkg;

   localparam int XLEN = 32;

   typedef logic [XLEN-1:0] word_t;
   typedef logic [XLEN-1:0] addr_t;
   typedef logic [4:0]      reg_addr_t;
   typedef logic [4:0]      cnt_t;

   // Major opcodes handled by the core
   typedef enum logic [6:0] {
      OPC_LUI    = 7'b0110111,
      OPC_OP_IMM = 7'b0010011,
      OPC_OP     = 7'b0110011,
      OPC_BRANCH = 7'b1100011,
      OPC_STORE  = 7'b0100011
   } opcode_e;

   typedef enum logic [2:0] {
      ALU_ADD    = 3'd0,
      ALU_SUB    = 3'd1,
      ALU_XOR    = 3'd2,
      ALU_OR     = 3'd3,
      ALU_AND    = 3'd4,
      ALU_PASS_B = 3'd5
   } alu_op_e;

   typedef struct packed {
      alu_op_e   alu_op;
      logic      op_b_imm;
      logic      rd_en;
      logic      is_branch;
      logic      branch_ne;
      logic      is_store;
      reg_addr_t rd;
      reg_addr_t rs1;
      reg_addr_t rs2;
      word_t     imm;
   } ctrl_t;

endpackage

// ==== rtl/core_bus_pkg.sv ====
package core_bus_pkg;

   typedef logic [3:0] sel_t;

   // Full word byte enables, only SW is supported
   localparam sel_t SEL_WORD = 4'b1111;

   typedef struct packed {
      logic                  cyc;
      core_types_pkg::addr_t adr;
   } ibus_req_t;

   typedef struct packed {
      logic                  cyc;
      logic                  we;
      sel_t                  sel;
      core_types_pkg::addr_t adr;
      core_types_pkg::word_t dat;
   } dbus_req_t;

endpackage

// ==== rtl/serial_decode.sv ====
`timescale 1ns/100ps

module serial_decode (
   input  logic                  clk,
   input  logic                  i_reset,
   input  logic                  i_ibus_ack,
   input  core_types_pkg::word_t i_ibus_rdt,
   input  logic                  i_dbus_ack,
   output core_types_pkg::ctrl_t o_ctrl,
   output core_types_pkg::cnt_t  o_cnt,
   output logic                  o_exec,
   output logic                  o_store_go,
   output logic                  o_retire
);

   typedef enum logic [2:0] {
      ST_FETCH,
      ST_DECODE,
      ST_EXEC,
      ST_STORE,
      ST_RETIRE
   } state_e;

   state_e                    state_q;
   core_types_pkg::cnt_t      cnt_q;
   core_types_pkg::word_t     ir_q;
   core_types_pkg::opcode_e   opcode;
   core_types_pkg::alu_op_e   f3_op;
   logic                      f3_ok;
   logic [2:0]                funct3;
   logic [6:0]                funct7;
   logic                      last_bit;

   assign opcode   = core_types_pkg::opcode_e'(ir_q[6:0]);
   assign funct3   = ir_q[14:12];
   assign funct7   = ir_q[31:25];
   assign last_bit = (cnt_q == 5'd31);

   always_ff @(posedge clk) begin
      if (i_reset) begin
         state_q <= ST_FETCH;
         cnt_q   <= '0;
      end else begin
         case (state_q)
            ST_FETCH:
               if (i_ibus_ack)
                  state_q <= ST_DECODE;
            ST_DECODE:
               state_q <= ST_EXEC;
            ST_EXEC: begin
               cnt_q <= cnt_q + 5'd1;
               if (last_bit)
                  state_q <= o_ctrl.is_store ? ST_STORE : ST_RETIRE;
            end
            ST_STORE:
               if (i_dbus_ack)
                  state_q <= ST_RETIRE;
            default:
               state_q <= ST_FETCH;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state_q == ST_FETCH && i_ibus_ack)
         ir_q <= i_ibus_rdt;
   end

   // Shared funct3 decode for OP and OP-IMM
   always_comb begin
      f3_ok = 1'b1;
      case (funct3)
         3'b000:  f3_op = core_types_pkg::ALU_ADD;
         3'b100:  f3_op = core_types_pkg::ALU_XOR;
         3'b110:  f3_op = core_types_pkg::ALU_OR;
         3'b111:  f3_op = core_types_pkg::ALU_AND;
         default: begin
            f3_op = core_types_pkg::ALU_ADD;
            f3_ok = 1'b0;
         end
      endcase
   end

   always_comb begin
      o_ctrl        = '0;
      o_ctrl.alu_op = core_types_pkg::ALU_ADD;
      o_ctrl.rd     = ir_q[11:7];
      o_ctrl.rs1    = ir_q[19:15];
      o_ctrl.rs2    = ir_q[24:20];
      o_ctrl.imm    = {{20{ir_q[31]}}, ir_q[31:20]};
      case (opcode)
         core_types_pkg::OPC_LUI: begin
            o_ctrl.alu_op   = core_types_pkg::ALU_PASS_B;
            o_ctrl.op_b_imm = 1'b1;
            o_ctrl.rd_en    = 1'b1;
            o_ctrl.imm      = {ir_q[31:12], 12'h000};
         end
         core_types_pkg::OPC_OP_IMM: begin
            o_ctrl.alu_op   = f3_op;
            o_ctrl.op_b_imm = 1'b1;
            o_ctrl.rd_en    = f3_ok;
         end
         core_types_pkg::OPC_OP: begin
            o_ctrl.alu_op = (funct3 == 3'b000 && funct7[5]) ? core_types_pkg::ALU_SUB : f3_op;
            o_ctrl.rd_en  = f3_ok &&
                            (funct7 == 7'b0 || (funct7 == 7'b0100000 && funct3 == 3'b000));
         end
         core_types_pkg::OPC_BRANCH: begin
            o_ctrl.is_branch = (funct3[2:1] == 2'b00);
            o_ctrl.branch_ne = funct3[0];
            o_ctrl.imm = {{19{ir_q[31]}}, ir_q[31], ir_q[7], ir_q[30:25], ir_q[11:8], 1'b0};
         end
         core_types_pkg::OPC_STORE: begin
            o_ctrl.is_store = (funct3 == 3'b010);
            o_ctrl.imm      = {{20{ir_q[31]}}, ir_q[31:25], ir_q[11:7]};
         end
         // Anything else only advances the PC
         default: ;
      endcase
   end

   assign o_cnt      = cnt_q;
   assign o_exec     = (state_q == ST_EXEC);
   assign o_store_go = o_exec && last_bit && o_ctrl.is_store;
   assign o_retire   = (state_q == ST_RETIRE);

endmodule

// ==== rtl/pc_ctrl.sv ====
`timescale 1ns/100ps

module pc_ctrl #(
   parameter core_types_pkg::addr_t RESET_PC = 32'd8
) (
   input  logic                     clk,
   input  logic                     i_reset,
   input  core_types_pkg::cnt_t     i_cnt,
   input  logic                     i_exec,
   input  logic                     i_retire,
   input  core_types_pkg::ctrl_t    i_ctrl,
   input  logic                     i_branch_taken,
   input  logic                     i_ibus_ack,
   output core_bus_pkg::ibus_req_t  o_ibus
);

   core_types_pkg::addr_t pc_q;
   core_types_pkg::addr_t plus4_q;
   core_types_pkg::addr_t target_q;
   logic                  cyc_q;
   logic                  c4_q;
   logic                  ct_q;
   logic                  c4_in;
   logic                  ct_in;
   logic                  pc_bit;
   logic                  four_bit;
   logic                  imm_bit;

   assign pc_bit   = pc_q[i_cnt];
   assign four_bit = (i_cnt == 5'd2);
   assign imm_bit  = i_ctrl.imm[i_cnt];
   assign c4_in    = (i_cnt == '0) ? 1'b0 : c4_q;
   assign ct_in    = (i_cnt == '0) ? 1'b0 : ct_q;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         pc_q  <= RESET_PC;
         cyc_q <= 1'b1;
         c4_q  <= 1'b0;
         ct_q  <= 1'b0;
      end else begin
         if (i_exec) begin
            c4_q <= (pc_bit & four_bit) | (c4_in & (pc_bit ^ four_bit));
            ct_q <= (pc_bit & imm_bit) | (ct_in & (pc_bit ^ imm_bit));
         end
         if (i_retire) begin
            pc_q  <= i_branch_taken ? target_q : plus4_q;
            cyc_q <= 1'b1;
         end else if (cyc_q && i_ibus_ack) begin
            cyc_q <= 1'b0;
         end
      end
   end

   // Next PC candidates, LSB first
   always_ff @(posedge clk) begin
      if (i_exec) begin
         plus4_q  <= {pc_bit ^ four_bit ^ c4_in, plus4_q[31:1]};
         target_q <= {pc_bit ^ imm_bit ^ ct_in, target_q[31:1]};
      end
   end

   assign o_ibus.cyc = cyc_q;
   assign o_ibus.adr = pc_q;

endmodule

// ==== rtl/serial_bufreg.sv ====
`timescale 1ns/100ps

module serial_bufreg (
   input  logic                  clk,
   input  logic                  i_reset,
   input  logic                  i_exec,
   input  core_types_pkg::cnt_t  i_cnt,
   input  logic                  i_rs1_bit,
   input  core_types_pkg::word_t i_imm,
   output core_types_pkg::addr_t o_adr
);

   core_types_pkg::addr_t adr_q;
   logic                  carry_q;
   logic                  carry_in;
   logic                  imm_bit;
   logic                  sum;

   assign imm_bit  = i_imm[i_cnt];
   assign carry_in = (i_cnt == '0) ? 1'b0 : carry_q;
   assign sum      = i_rs1_bit ^ imm_bit ^ carry_in;

   always_ff @(posedge clk) begin
      if (i_reset)
         carry_q <= 1'b0;
      else if (i_exec)
         carry_q <= (i_rs1_bit & imm_bit) | (carry_in & (i_rs1_bit ^ imm_bit));
   end

   // Sum enters at the top and settles into place after 32 cycles
   always_ff @(posedge clk) begin
      if (i_exec)
         adr_q <= {sum, adr_q[31:1]};
   end

   assign o_adr = {adr_q[31:2], 2'b00};

endmodule

// ==== rtl/serial_alu.sv ====
`timescale 1ns/100ps

module serial_alu (
   input  logic                  clk,
   input  logic                  i_reset,
   input  logic                  i_exec,
   input  core_types_pkg::cnt_t  i_cnt,
   input  core_types_pkg::ctrl_t i_ctrl,
   input  logic                  i_rs1_bit,
   input  logic                  i_rs2_bit,
   output logic                  o_rd_bit,
   output logic                  o_branch_taken
);

   logic op_b;
   logic b_inv;
   logic is_sub;
   logic carry_q;
   logic carry_in;
   logic sum;
   logic diff;
   logic diff_q;

   assign op_b     = i_ctrl.op_b_imm ? i_ctrl.imm[i_cnt] : i_rs2_bit;
   assign is_sub   = (i_ctrl.alu_op == core_types_pkg::ALU_SUB);
   assign b_inv    = op_b ^ is_sub;
   // Carry starts at one for subtraction
   assign carry_in = (i_cnt == '0) ? is_sub : carry_q;
   assign sum      = i_rs1_bit ^ b_inv ^ carry_in;
   assign diff     = i_rs1_bit ^ op_b;

   always_comb begin
      case (i_ctrl.alu_op)
         core_types_pkg::ALU_XOR:    o_rd_bit = i_rs1_bit ^ op_b;
         core_types_pkg::ALU_OR:     o_rd_bit = i_rs1_bit | op_b;
         core_types_pkg::ALU_AND:    o_rd_bit = i_rs1_bit & op_b;
         core_types_pkg::ALU_PASS_B: o_rd_bit = op_b;
         default:                    o_rd_bit = sum;
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_reset) begin
         carry_q <= 1'b0;
         diff_q  <= 1'b0;
      end else if (i_exec) begin
         carry_q <= (i_rs1_bit & b_inv) | (carry_in & (i_rs1_bit ^ b_inv));
         // Sticky mismatch over the whole word
         diff_q  <= (i_cnt == '0) ? diff : (diff_q | diff);
      end
   end

   assign o_branch_taken = i_ctrl.is_branch & (i_ctrl.branch_ne ? diff_q : ~diff_q);

endmodule

// ==== rtl/serial_regfile.sv ====
`timescale 1ns/100ps

module serial_regfile (
   input  logic                  clk,
   input  logic                  i_reset,
   input  logic                  i_exec,
   input  core_types_pkg::cnt_t  i_cnt,
   input  core_types_pkg::ctrl_t i_ctrl,
   input  logic                  i_rd_bit,
   output logic                  o_rs1_bit,
   output logic                  o_rs2_bit
);

   // x1..x31, x0 reads as zero
   core_types_pkg::word_t regs [1:31];

   logic wr_en;

   assign wr_en = i_exec && i_ctrl.rd_en && (i_ctrl.rd != '0);

   assign o_rs1_bit = (i_ctrl.rs1 == '0) ? 1'b0 : regs[i_ctrl.rs1][i_cnt];
   assign o_rs2_bit = (i_ctrl.rs2 == '0) ? 1'b0 : regs[i_ctrl.rs2][i_cnt];

   // Bit cnt is already read when it gets overwritten
   always_ff @(posedge clk) begin
      if (i_reset) begin
         for (int i = 1; i < 32; i++)
            regs[i] <= '0;
      end else if (wr_en) begin
         regs[i_ctrl.rd][i_cnt] <= i_rd_bit;
      end
   end

endmodule

// ==== rtl/store_if.sv ====
`timescale 1ns/100ps

module store_if (
   input  logic                    clk,
   input  logic                    i_reset,
   input  logic                    i_exec,
   input  core_types_pkg::cnt_t    i_cnt,
   input  logic                    i_rs2_bit,
   input  logic                    i_store_go,
   input  core_types_pkg::addr_t   i_adr,
   input  logic                    i_dbus_ack,
   output core_bus_pkg::dbus_req_t o_dbus
);

   core_types_pkg::word_t dat_q;
   logic                  cyc_q;

   // Store data, one rs2 bit per execute cycle
   always_ff @(posedge clk) begin
      if (i_exec)
         dat_q[i_cnt] <= i_rs2_bit;
   end

   always_ff @(posedge clk) begin
      if (i_reset)
         cyc_q <= 1'b0;
      else if (i_store_go)
         cyc_q <= 1'b1;
      else if (cyc_q && i_dbus_ack)
         cyc_q <= 1'b0;
   end

   assign o_dbus.cyc = cyc_q;
   assign o_dbus.we  = 1'b1;
   assign o_dbus.sel = core_bus_pkg::SEL_WORD;
   assign o_dbus.adr = i_adr;
   assign o_dbus.dat = dat_q;

endmodule

// ==== rtl/serv_core_top.sv ====
`timescale 1ns/100ps

module serv_core_top #(
   parameter core_types_pkg::addr_t RESET_PC = 32'd8
) (
   input  logic                    clk,
   input  logic                    i_reset,
   input  core_types_pkg::word_t   i_ibus_rdt,
   input  logic                    i_ibus_ack,
   input  logic                    i_dbus_ack,
   output core_bus_pkg::ibus_req_t o_ibus,
   output core_bus_pkg::dbus_req_t o_dbus
);

   core_types_pkg::ctrl_t ctrl;
   core_types_pkg::cnt_t  cnt;
   core_types_pkg::addr_t store_adr;
   logic                  exec;
   logic                  store_go;
   logic                  retire;
   logic                  rs1_bit;
   logic                  rs2_bit;
   logic                  rd_bit;
   logic                  branch_taken;

   serial_decode u_decode (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_ibus_ack (i_ibus_ack),
      .i_ibus_rdt (i_ibus_rdt),
      .i_dbus_ack (i_dbus_ack),
      .o_ctrl     (ctrl),
      .o_cnt      (cnt),
      .o_exec     (exec),
      .o_store_go (store_go),
      .o_retire   (retire)
   );

   pc_ctrl #(
      .RESET_PC (RESET_PC)
   ) u_pc_ctrl (
      .clk            (clk),
      .i_reset        (i_reset),
      .i_cnt          (cnt),
      .i_exec         (exec),
      .i_retire       (retire),
      .i_ctrl         (ctrl),
      .i_branch_taken (branch_taken),
      .i_ibus_ack     (i_ibus_ack),
      .o_ibus         (o_ibus)
   );

   serial_regfile u_regfile (
      .clk       (clk),
      .i_reset   (i_reset),
      .i_exec    (exec),
      .i_cnt     (cnt),
      .i_ctrl    (ctrl),
      .i_rd_bit  (rd_bit),
      .o_rs1_bit (rs1_bit),
      .o_rs2_bit (rs2_bit)
   );

   serial_alu u_alu (
      .clk            (clk),
      .i_reset        (i_reset),
      .i_exec         (exec),
      .i_cnt          (cnt),
      .i_ctrl         (ctrl),
      .i_rs1_bit      (rs1_bit),
      .i_rs2_bit      (rs2_bit),
      .o_rd_bit       (rd_bit),
      .o_branch_taken (branch_taken)
   );

   serial_bufreg u_bufreg (
      .clk       (clk),
      .i_reset   (i_reset),
      .i_exec    (exec),
      .i_cnt     (cnt),
      .i_rs1_bit (rs1_bit),
      .i_imm     (ctrl.imm),
      .o_adr     (store_adr)
   );

   store_if u_store_if (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_exec     (exec),
      .i_cnt      (cnt),
      .i_rs2_bit  (rs2_bit),
      .i_store_go (store_go),
      .i_adr      (store_adr),
      .i_dbus_ack (i_dbus_ack),
      .o_dbus     (o_dbus)
   );

endmodule

// ==== verif/core_props.sv ====
`timescale 1ns/100ps

module core_props (
   input logic                    clk,
   input logic                    i_reset,
   input logic                    i_ibus_ack,
   input logic                    i_dbus_ack,
   input core_bus_pkg::ibus_req_t o_ibus,
   input core_bus_pkg::dbus_req_t o_dbus
);

   int fail_count = 0;

   // Requests hold until acknowledged
   ibus_hold: assert property (@(posedge clk) disable iff (i_reset)
      o_ibus.cyc && !i_ibus_ack |=> o_ibus.cyc && $stable(o_ibus.adr))
      else begin
         $error("instruction bus request changed before ack");
         fail_count++;
      end

   dbus_hold: assert property (@(posedge clk) disable iff (i_reset)
      o_dbus.cyc && !i_dbus_ack |=> $stable(o_dbus))
      else begin
         $error("data bus request changed before ack");
         fail_count++;
      end

   ibus_drop: assert property (@(posedge clk) disable iff (i_reset)
      o_ibus.cyc && i_ibus_ack |=> !o_ibus.cyc)
      else begin
         $error("instruction bus cyc still high after ack");
         fail_count++;
      end

   dbus_drop: assert property (@(posedge clk) disable iff (i_reset)
      o_dbus.cyc && i_dbus_ack |=> !o_dbus.cyc)
      else begin
         $error("data bus cyc still high after ack");
         fail_count++;
      end

endmodule

bind serv_core_top core_props u_props (
   .clk        (clk),
   .i_reset    (i_reset),
   .i_ibus_ack (i_ibus_ack),
   .i_dbus_ack (i_dbus_ack),
   .o_ibus     (o_ibus),
   .o_dbus     (o_dbus)
);

// ==== verif/tb_core.sv ====
`timescale 1ns/100ps

module tb_core;

   localparam core_types_pkg::addr_t RESET_PC = 32'h0000_0040;
   localparam int NUM_INSNS = 300;
   localparam int TIMEOUT   = 200;

   logic                    clk;
   logic                    i_reset;
   core_types_pkg::word_t   i_ibus_rdt;
   logic                    i_ibus_ack;
   logic                    i_dbus_ack;
   core_bus_pkg::ibus_req_t o_ibus;
   core_bus_pkg::dbus_req_t o_dbus;

   logic [15:0]           lfsr_q;
   core_types_pkg::word_t model_regs [0:31];
   core_types_pkg::addr_t model_pc;
   logic                  exp_store;
   core_types_pkg::addr_t exp_store_adr;
   core_types_pkg::word_t exp_store_dat;
   int                    exp_lat;
   int                    mismatches;
   int                    protocol_errors;
   int                    timeouts;
   int                    stores;
   int                    taken;
   int                    total_errors;
   logic                  timed_out;

   serv_core_top #(
      .RESET_PC (RESET_PC)
   ) dut (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .i_dbus_ack (i_dbus_ack),
      .o_ibus     (o_ibus),
      .o_dbus     (o_dbus)
   );

   always #20 clk = ~clk;

   // Galois LFSR with taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      logic [15:0] n;
      n = s >> 1;
      if (s[0])
         n = n ^ 16'hB400;
      return n;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_next(lfsr_q);
         v = {v[30:0], lfsr_q[0]};
      end
      return v;
   endfunction

   function automatic core_types_pkg::word_t gen_insn();
      logic [3:0]            kind;
      logic [4:0]            rd;
      logic [4:0]            rs1;
      logic [4:0]            rs2;
      logic [2:0]            f3;
      core_types_pkg::word_t w;
      kind = 4'(rand_bits(4));
      // Few registers so stores often read back earlier results
      rd  = {2'b00, 3'(rand_bits(3))};
      rs1 = {2'b00, 3'(rand_bits(3))};
      rs2 = {2'b00, 3'(rand_bits(3))};
      f3  = 3'(rand_bits(3));
      if (kind < 4'd2) begin
         w = {20'(rand_bits(20)), rd, core_types_pkg::OPC_LUI};
      end else if (kind < 4'd6) begin
         w = {12'(rand_bits(12)), rs1, f3, rd, core_types_pkg::OPC_OP_IMM};
      end else if (kind < 4'd9) begin
         if (rand_bits(2) == 0)
            w = {7'h20, rs2, rs1, 3'b000, rd, core_types_pkg::OPC_OP};
         else
            w = {7'h00, rs2, rs1, f3, rd, core_types_pkg::OPC_OP};
      end else if (kind < 4'd11) begin
         // imm[1] sits in bit 8 and stays clear for word aligned targets
         w = {7'(rand_bits(7)), rs2, rs1, 2'b00, f3[0], 3'(rand_bits(3)), 1'b0,
              1'(rand_bits(1)), core_types_pkg::OPC_BRANCH};
      end else if (kind < 4'd14) begin
         w = {7'(rand_bits(7)), rs2, rs1, (f3 == 3'b111) ? 3'b001 : 3'b010,
              5'(rand_bits(5)), core_types_pkg::OPC_STORE};
      end else begin
         w = rand_bits(32);
      end
      return w;
   endfunction

   task automatic model_exec(input core_types_pkg::word_t w);
      logic [2:0]            f3;
      logic [6:0]            f7;
      logic                  wr;
      core_types_pkg::word_t a;
      core_types_pkg::word_t b;
      core_types_pkg::word_t imm_i;
      core_types_pkg::word_t res;
      core_types_pkg::addr_t next_pc;
      f3      = w[14:12];
      f7      = w[31:25];
      a       = model_regs[w[19:15]];
      b       = model_regs[w[24:20]];
      imm_i   = {{20{w[31]}}, w[31:20]};
      res     = '0;
      wr      = 1'b0;
      next_pc = model_pc + 32'd4;
      exp_store = 1'b0;
      case (w[6:0])
         core_types_pkg::OPC_LUI: begin
            res = {w[31:12], 12'h000};
            wr  = 1'b1;
         end
         core_types_pkg::OPC_OP_IMM, core_types_pkg::OPC_OP: begin
            if (w[6:0] == core_types_pkg::OPC_OP_IMM || f7 == 7'h00)
               wr = 1'b1;
            if (w[6:0] == core_types_pkg::OPC_OP_IMM)
               b = imm_i;
            case (f3)
               3'b000:  res = a + b;
               3'b100:  res = a ^ b;
               3'b110:  res = a | b;
               3'b111:  res = a & b;
               default: wr = 1'b0;
            endcase
            if (w[6:0] == core_types_pkg::OPC_OP && f7 == 7'h20 && f3 == 3'b000) begin
               res = a - b;
               wr  = 1'b1;
            end
         end
         core_types_pkg::OPC_BRANCH: begin
            if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b)) begin
               next_pc = model_pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
               taken++;
            end
         end
         core_types_pkg::OPC_STORE: begin
            if (f3 == 3'b010) begin
               exp_store     = 1'b1;
               exp_store_adr = (a + {{20{w[31]}}, w[31:25], w[11:7]}) & ~32'h3;
               exp_store_dat = b;
               stores++;
            end
         end
         default: ;
      endcase
      if (wr && w[11:7] != 5'd0)
         model_regs[w[11:7]] = res;
      model_pc = next_pc;
   endtask

   task automatic check_adr(input core_types_pkg::addr_t got,
                            input core_types_pkg::addr_t exp, input string what);
      if (got !== exp) begin
         $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
         mismatches++;
      end
   endtask

   task automatic check_word(input core_types_pkg::word_t got,
                             input core_types_pkg::word_t exp, input string what);
      if (got !== exp) begin
         $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
         mismatches++;
      end
   endtask

   task automatic check_sel(input core_bus_pkg::sel_t got,
                            input core_bus_pkg::sel_t exp, input string what);
      if (got !== exp) begin
         $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
         mismatches++;
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
         mismatches++;
      end
   endtask

   task automatic step();
      @(posedge clk);
      #2;
   endtask

   task automatic check_latency(input int got, input int exp, input string what);
      if (got != exp) begin
         $display("%s came %0d cycles after the handshake instead of %0d, at %0t",
                  what, got, exp, $time);
         protocol_errors++;
      end
   endtask

   // No data bus request may show up while waiting for a fetch
   task automatic wait_fetch(output int cycles);
      cycles = 0;
      while (!o_ibus.cyc && !timed_out) begin
         if (o_dbus.cyc) begin
            $display("data bus request without a store instruction at %0t", $time);
            protocol_errors++;
         end
         step();
         cycles++;
         if (cycles >= TIMEOUT) begin
            $display("timeout: no instruction fetch within %0d cycles", TIMEOUT);
            timeouts++;
            timed_out = 1'b1;
         end
      end
   endtask

   task automatic wait_store(output int cycles);
      cycles = 0;
      while (!o_dbus.cyc && !timed_out) begin
         if (o_ibus.cyc) begin
            $display("instruction fetch before the store at %0t", $time);
            protocol_errors++;
         end
         step();
         cycles++;
         if (cycles >= TIMEOUT) begin
            $display("timeout: no store request within %0d cycles", TIMEOUT);
            timeouts++;
            timed_out = 1'b1;
         end
      end
   endtask

   task automatic run_insn();
      int                    lat;
      int                    delay;
      core_types_pkg::word_t w;
      wait_fetch(lat);
      if (!timed_out) begin
         check_latency(lat, exp_lat, "fetch");
         check_adr(o_ibus.adr, model_pc, "fetch address");
         delay      = int'(rand_bits(2));
         i_ibus_rdt = rand_bits(32);
         repeat (delay) step();
         w          = gen_insn();
         i_ibus_rdt = w;
         i_ibus_ack = 1'b1;
         step();
         i_ibus_ack = 1'b0;
         i_ibus_rdt = ~w;
         model_exec(w);
         exp_lat = 34;
         if (exp_store) begin
            wait_store(lat);
            if (!timed_out) begin
               check_latency(lat, 33, "store request");
               check_adr(o_dbus.adr, exp_store_adr, "store address");
               check_word(o_dbus.dat, exp_store_dat, "store data");
               check_flag(o_dbus.we, 1'b1, "store write enable");
               check_sel(o_dbus.sel, 4'b1111, "store byte select");
               delay = int'(rand_bits(2));
               repeat (delay) step();
               i_dbus_ack = 1'b1;
               step();
               i_dbus_ack = 1'b0;
               exp_lat = 1;
            end
         end
      end
   endtask

   initial begin
      clk             = 1'b0;
      i_reset         = 1'b1;
      i_ibus_rdt      = '0;
      i_ibus_ack      = 1'b0;
      i_dbus_ack      = 1'b0;
      lfsr_q          = 16'd1510;
      model_pc        = RESET_PC;
      exp_store       = 1'b0;
      exp_lat         = 0;
      mismatches      = 0;
      protocol_errors = 0;
      timeouts        = 0;
      stores          = 0;
      taken           = 0;
      timed_out       = 1'b0;
      for (int i = 0; i < 32; i++)
         model_regs[i] = '0;
      repeat (3) @(posedge clk);
      #2;
      i_reset = 1'b0;
      if (o_dbus.cyc) begin
         $display("data bus request active right after reset");
         protocol_errors++;
      end
      check_adr(o_ibus.adr, RESET_PC, "address after reset");
      for (int n = 0; n < NUM_INSNS && !timed_out; n++)
         run_insn();
      total_errors = mismatches + protocol_errors + timeouts + dut.u_props.fail_count;
      $display("ran %0d instructions with %0d stores and %0d taken branches",
               NUM_INSNS, stores, taken);
      $display("errors: %0d mismatch, %0d protocol, %0d assertion, %0d timeout",
               mismatches, protocol_errors, dut.u_props.fail_count, timeouts);
      if (total_errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// ==== project.f ====
rtl/core_types_pkg.sv
rtl/core_bus_pkg.sv
rtl/serial_decode.sv
rtl/pc_ctrl.sv
rtl/serial_bufreg.sv
rtl/serial_alu.sv
rtl/serial_regfile.sv
rtl/store_if.sv
rtl/serv_core_top.sv
verif/core_props.sv
verif/tb_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_core -f project.f

# Pass or fail is read from the log below
./obj_dir/Vtb_core +verilator+error+limit+1000 | tee sim.log

if grep -q "TEST PASSED" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed, see sim.log"
   exit 1
fi
